// File: hdl/cap_pkg.sv
// shared codes for the capture unit; the word address is 12 bits, so byte addresses above 0x3FFF alias
package cap_pkg;

  // --------------------
  // constants
  // --------------------
  // apb word address width, byte address bits [13:2]
  localparam int unsigned cap_addr_w = 12;

  localparam logic [31:0] who_am_i_value = 32'h5A7E_0C01;
  localparam logic [31:0] dead_value     = 32'hDEAD_DEAD;

  // --------------------
  // register indices
  // --------------------
  localparam logic [3:0] reg_who_am_i   = 4'd0;
  localparam logic [3:0] reg_capt_depth = 4'd1;
  localparam logic [3:0] reg_data_w     = 4'd2;
  localparam logic [3:0] reg_trig_mode  = 4'd3;
  localparam logic [3:0] reg_trig_count = 4'd4;
  localparam logic [3:0] reg_capt_count = 4'd5;
  localparam logic [3:0] reg_go         = 4'd6;
  localparam logic [3:0] reg_capt_state = 4'd7;
  localparam logic [3:0] reg_trig_mask1 = 4'd8;
  localparam logic [3:0] reg_trig_mask2 = 4'd9;
  localparam logic [3:0] reg_trig_val1  = 4'd10;
  localparam logic [3:0] reg_trig_val2  = 4'd11;

  // trigger modes, code 3 behaves like single
  localparam logic [1:0] trig_none       = 2'd0;
  localparam logic [1:0] trig_single     = 2'd1;
  localparam logic [1:0] trig_continuous = 2'd2;

  // capture states as seen through the capt_state register
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_armed   = 2'd1;
  localparam logic [1:0] st_capture = 2'd2;
  localparam logic [1:0] st_done    = 2'd3;

  // the top bit picks memory over registers, so memory starts at word 2048
  typedef union packed {
    struct packed {
      logic       mem_sel;
      logic [6:0] unused;
      logic [3:0] reg_idx;
    } regs;
    struct packed {
      logic        mem_sel;
      logic [10:0] mem_idx;
    } mem;
  } cap_addr_u;

endpackage

// File: hdl/cap_cfg_if.sv
// configuration and status between register block, trigger detector and capture engine; data_w <= 32
`timescale 1ns/1ps

interface cap_cfg_if #(
  parameter int data_w = 16
);

  // set over apb
  logic [1:0]        trig_mode;
  logic              go;
  logic [data_w-1:0] trig_mask1;
  logic [data_w-1:0] trig_mask2;
  logic [data_w-1:0] trig_val1;
  logic [data_w-1:0] trig_val2;

  // reported back by the engine, both events are single-cycle pulses
  logic              trig_event;
  logic              capt_done;
  logic [1:0]        state;

  modport regs_mp (
    output trig_mode, go, trig_mask1, trig_mask2, trig_val1, trig_val2,
    input  trig_event, capt_done, state
  );

  modport detect_mp (
    input trig_mask1, trig_mask2, trig_val1, trig_val2
  );

  modport engine_mp (
    input  trig_mode, go,
    output trig_event, capt_done, state
  );

endinterface

// File: hdl/cap_ram.sv
// capture memory with one write port and a registered read; contents are undefined after power-up
`timescale 1ns/1ps

module cap_ram #(
  parameter int data_w     = 16,
  parameter int capt_depth = 16
) (
  input  logic                          clk,
  input  logic                          wr_en_i,
  input  logic [$clog2(capt_depth)-1:0] wr_addr_i,
  input  logic [data_w-1:0]             wr_data_i,
  input  logic [$clog2(capt_depth)-1:0] rd_addr_i,
  output logic [data_w-1:0]             rd_data_o
);

  logic [data_w-1:0] mem [capt_depth];

  // read and write may hit the same word, the read then returns the old data
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: hdl/trig_detect.sv
// two-stage masked compare for edge triggers; hit and data lag din_i by two register stages
`timescale 1ns/1ps

module trig_detect #(
  parameter int data_w = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [data_w-1:0] din_i,
  cap_cfg_if.detect_mp      cfg,
  output logic              hit_o,
  output logic [data_w-1:0] data_o
);

  logic [data_w-1:0] din_d;
  logic [data_w-1:0] din_dd;
  logic              match1;
  logic              match2;

  // --------------------
  // delay line
  // --------------------
  // din_d is the newer sample, din_dd the one before it
  always_ff @(posedge clk) begin
    din_d  <= din_i;
    din_dd <= din_d;
  end

  // a cleared mask bit makes that bit a don't care
  assign match1 = ((din_dd ^ cfg.trig_val1) & cfg.trig_mask1) == '0;
  assign match2 = ((din_d ^ cfg.trig_val2) & cfg.trig_mask2) == '0;

  // --------------------
  // output stage
  // --------------------
  // the hit travels with the sample that completed the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= match1 && match2;
    end
  end

  always_ff @(posedge clk) begin
    data_o <= din_d;
  end

endmodule

// File: hdl/cap_engine.sv
// capture fsm; the trigger sample lands at word 0 and there is no pre-trigger history
`timescale 1ns/1ps

module cap_engine #(
  parameter int data_w     = 16,
  parameter int capt_depth = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          hit_i,
  input  logic [data_w-1:0]             data_i,
  cap_cfg_if.engine_mp                  cfg,
  output logic                          wr_en_o,
  output logic [$clog2(capt_depth)-1:0] wr_addr_o,
  output logic [data_w-1:0]             wr_data_o
);

  import cap_pkg::*;

  localparam int aw = $clog2(capt_depth);
  localparam logic [aw-1:0] last_addr = aw'(capt_depth - 1);

  logic [1:0]    state;
  logic [1:0]    state_n;
  logic [aw-1:0] wr_addr;
  logic [aw-1:0] wr_addr_n;
  logic          done;
  logic          restart;

  // every sample goes straight to memory and the fsm only picks where and when
  assign wr_data_o = data_i;

  // continuous mode throws away a partial fill on each new trigger
  assign restart = (cfg.trig_mode == trig_continuous) && hit_i;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_n   = state;
    wr_addr_n = wr_addr;
    wr_en_o   = 1'b0;
    wr_addr_o = wr_addr;
    done      = 1'b0;
    case (state)
      st_idle: begin
        wr_addr_n = '0;
        if (cfg.go) begin
          state_n = (cfg.trig_mode == trig_none) ? st_capture : st_armed;
        end
      end
      st_armed: begin
        if (hit_i) begin
          wr_en_o   = 1'b1;
          wr_addr_o = '0;
          wr_addr_n = aw'(1);
          state_n   = st_capture;
        end
      end
      st_capture: begin
        wr_en_o = 1'b1;
        if (restart) begin
          wr_addr_o = '0;
          wr_addr_n = aw'(1);
        end else if (wr_addr == last_addr) begin
          done      = 1'b1;
          wr_addr_n = '0;
          state_n   = (cfg.trig_mode == trig_continuous) ? st_armed : st_done;
        end else begin
          wr_addr_n = wr_addr + aw'(1);
        end
      end
      // st_done just holds until go is dropped
      default: ;
    endcase
    // dropping go aborts whatever is running
    if (!cfg.go) begin
      state_n = st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      wr_addr <= '0;
    end else begin
      state   <= state_n;
      wr_addr <= wr_addr_n;
    end
  end

  // --------------------
  // status to registers
  // --------------------
  assign cfg.state      = state;
  assign cfg.capt_done  = done;
  // only triggers that matter to a running capture are counted
  assign cfg.trig_event = hit_i && cfg.go && (cfg.trig_mode != trig_none);

  // a fill starts at word 0 and every later write follows the one just before it
  a_wr_legal : assert property (@(posedge clk) disable iff (rst)
    wr_en_o && (wr_addr_o != '0) |->
      $past(wr_en_o) && (wr_addr_o == $past(wr_addr_o) + aw'(1)));

  // a finished fill writes the top word right after the word below it
  a_done_last : assert property (@(posedge clk) disable iff (rst)
    done |-> wr_en_o && (wr_addr_o == last_addr) && $past(wr_en_o) &&
             ($past(wr_addr_o) == last_addr - aw'(1)));

endmodule

// File: hdl/cap_regs.sv
// apb slave; expects one transfer at a time and memory indices past capt_depth alias back into the array
`timescale 1ns/1ps

module cap_regs #(
  parameter int data_w     = 16,
  parameter int capt_depth = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [31:0]                   paddr_i,
  input  logic                          pwrite_i,
  input  logic [31:0]                   pwdata_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  output logic                          pready_o,
  output logic [31:0]                   prdata_o,
  cap_cfg_if.regs_mp                    cfg,
  output logic [$clog2(capt_depth)-1:0] ram_rd_addr_o,
  input  logic [data_w-1:0]             ram_rd_data_i
);

  import cap_pkg::*;

  localparam int aw = $clog2(capt_depth);

  cap_addr_u   addr;
  logic        setup;
  logic        mem_rd_pend;
  logic [31:0] trig_count;
  logic [31:0] capt_count;
  logic [31:0] reg_rdata;

  // word address, the byte lanes are ignored
  assign addr  = paddr_i[cap_addr_w+1:2];
  // a transfer is taken in its setup phase only
  assign setup = psel_i && !penable_i;

  // the ram sees the address during setup and answers one edge later
  assign ram_rd_addr_o = addr.mem.mem_idx[aw-1:0];

  // --------------------
  // register readback
  // --------------------
  always_comb begin
    reg_rdata = dead_value;
    // anything with the padding bits set is unmapped
    if (addr.regs.unused == '0) begin
      case (addr.regs.reg_idx)
        reg_who_am_i:   reg_rdata = who_am_i_value;
        reg_capt_depth: reg_rdata = 32'(capt_depth);
        reg_data_w:     reg_rdata = 32'(data_w);
        reg_trig_mode:  reg_rdata = {30'd0, cfg.trig_mode};
        reg_trig_count: reg_rdata = trig_count;
        reg_capt_count: reg_rdata = capt_count;
        reg_go:         reg_rdata = {31'd0, cfg.go};
        reg_capt_state: reg_rdata = {30'd0, cfg.state};
        reg_trig_mask1: reg_rdata = 32'(cfg.trig_mask1);
        reg_trig_mask2: reg_rdata = 32'(cfg.trig_mask2);
        reg_trig_val1:  reg_rdata = 32'(cfg.trig_val1);
        reg_trig_val2:  reg_rdata = 32'(cfg.trig_val2);
        default:        reg_rdata = dead_value;
      endcase
    end
  end

  // --------------------
  // control and counters
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pready_o       <= 1'b0;
      mem_rd_pend    <= 1'b0;
      cfg.trig_mode  <= trig_none;
      cfg.go         <= 1'b0;
      cfg.trig_mask1 <= '0;
      cfg.trig_mask2 <= '0;
      cfg.trig_val1  <= '0;
      cfg.trig_val2  <= '0;
      trig_count     <= '0;
      capt_count     <= '0;
    end else begin
      pready_o    <= 1'b0;
      mem_rd_pend <= 1'b0;
      // counting comes first so a register write below overrides it
      if (cfg.trig_event) begin
        trig_count <= trig_count + 32'd1;
      end
      if (cfg.capt_done) begin
        capt_count <= capt_count + 32'd1;
      end
      if (setup) begin
        if (pwrite_i) begin
          // writes to memory or read-only slots still complete, they just do nothing
          pready_o <= 1'b1;
          if (!addr.regs.mem_sel && addr.regs.unused == '0) begin
            case (addr.regs.reg_idx)
              reg_trig_mode:  cfg.trig_mode  <= pwdata_i[1:0];
              reg_trig_count: trig_count     <= pwdata_i;
              reg_capt_count: capt_count     <= pwdata_i;
              reg_go:         cfg.go         <= pwdata_i[0];
              reg_trig_mask1: cfg.trig_mask1 <= pwdata_i[data_w-1:0];
              reg_trig_mask2: cfg.trig_mask2 <= pwdata_i[data_w-1:0];
              reg_trig_val1:  cfg.trig_val1  <= pwdata_i[data_w-1:0];
              reg_trig_val2:  cfg.trig_val2  <= pwdata_i[data_w-1:0];
              default: ;
            endcase
          end
        end else if (addr.mem.mem_sel) begin
          // memory reads wait one more cycle for the registered ram output
          mem_rd_pend <= 1'b1;
        end else begin
          pready_o <= 1'b1;
        end
      end
      if (mem_rd_pend) begin
        pready_o <= 1'b1;
      end
    end
  end

  // read data is only meaningful while pready_o is high
  always_ff @(posedge clk) begin
    if (setup && !pwrite_i && !addr.regs.mem_sel) begin
      prdata_o <= reg_rdata;
    end
    if (mem_rd_pend) begin
      prdata_o <= 32'(ram_rd_data_i);
    end
  end

  // each transfer gets exactly one ready pulse, never a stretched one
  a_pready_pulse : assert property (@(posedge clk) disable iff (rst) pready_o |=> !pready_o);

endmodule

// File: hdl/wave_capture.sv
// capture unit top; data_w must be at most 32 and capt_depth a power of two from 2 to 2048
`timescale 1ns/1ps

module wave_capture #(
  parameter int data_w     = 16,
  parameter int capt_depth = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [data_w-1:0] din_i,
  input  logic [31:0]       paddr_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  input  logic              psel_i,
  input  logic              penable_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o
);

  localparam int aw = $clog2(capt_depth);

  logic              hit;
  logic [data_w-1:0] trig_data;
  logic              wr_en;
  logic [aw-1:0]     wr_addr;
  logic [data_w-1:0] wr_data;
  logic [aw-1:0]     rd_addr;
  logic [data_w-1:0] rd_data;

  // the slave never signals an error
  assign pslverr_o = 1'b0;

  cap_cfg_if #(.data_w(data_w)) cfg ();

  // --------------------
  // register block
  // --------------------
  cap_regs #(.data_w(data_w), .capt_depth(capt_depth)) u_regs (
    .clk           (clk),
    .rst           (rst),
    .paddr_i       (paddr_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pready_o      (pready_o),
    .prdata_o      (prdata_o),
    .cfg           (cfg.regs_mp),
    .ram_rd_addr_o (rd_addr),
    .ram_rd_data_i (rd_data)
  );

  // --------------------
  // datapath
  // --------------------
  trig_detect #(.data_w(data_w)) u_detect (
    .clk    (clk),
    .rst    (rst),
    .din_i  (din_i),
    .cfg    (cfg.detect_mp),
    .hit_o  (hit),
    .data_o (trig_data)
  );

  cap_engine #(.data_w(data_w), .capt_depth(capt_depth)) u_engine (
    .clk       (clk),
    .rst       (rst),
    .hit_i     (hit),
    .data_i    (trig_data),
    .cfg       (cfg.engine_mp),
    .wr_en_o   (wr_en),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data)
  );

  cap_ram #(.data_w(data_w), .capt_depth(capt_depth)) u_ram (
    .clk       (clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

// File: bench/cap_checker.sv
// compares apb read data under a mask and counts errors; expectations come from the bench
`timescale 1ns/1ps

module cap_checker (
  input  logic         clk,
  input  logic         pready_i,
  input  logic [31:0]  prdata_i,
  input  logic         pslverr_i,
  input  logic         chk_en_i,
  input  logic         chk_poll_i,
  input  logic [31:0]  exp_data_i,
  input  logic [31:0]  exp_mask_i,
  input  logic [127:0] test_name_i,
  input  logic         test_end_i,
  input  logic         poll_expired_i,
  input  logic         no_resp_i,
  input  logic         summary_i,
  output logic         match_o,
  output int           errors_o
);

  int total_errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int checks = 0;
  logic same;

  initial begin
    match_o  = 1'b0;
    errors_o = 0;
  end

  // only bits set in the mask take part in a compare
  assign same = ((prdata_i ^ exp_data_i) & exp_mask_i) == 32'd0;

  always @(posedge clk) begin
    // the slave has no error response, so any pslverr is a fault
    if (pready_i && pslverr_i) begin
      $display("CHECK FAILED at %0t: pslverr high on a response", $time);
      total_errors++;
      test_errors++;
    end
    if (pready_i && chk_en_i) begin
      match_o <= same;
      // a poll sample that differs just means the bench retries
      if (!chk_poll_i) begin
        checks++;
        if (!same) begin
          $display("CHECK FAILED at %0t: read %h, expected %h under mask %h",
                   $time, prdata_i, exp_data_i, exp_mask_i);
          total_errors++;
          test_errors++;
        end
      end
    end
    if (poll_expired_i) begin
      $display("poll at %0t in %0s gave up waiting for %h", $time, test_name_i, exp_data_i);
      total_errors++;
      test_errors++;
    end
    if (no_resp_i) begin
      $display("the slave never answered an APB transfer at %0t in %0s", $time, test_name_i);
      total_errors++;
      test_errors++;
    end
    if (test_end_i) begin
      tests_run++;
      if (test_errors == 0) begin
        $display("test %0s: pass", test_name_i);
      end else begin
        $display("test %0s: fail with %0d errors", test_name_i, test_errors);
        tests_bad++;
      end
      test_errors = 0;
    end
    if (summary_i) begin
      $display("tests %0d, failing %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, total_errors);
    end
    errors_o <= total_errors;
  end

endmodule

// File: bench/tb_wave_capture.sv
// capture unit bench; run from the project root, data_w 16 and capt_depth 16 are assumed
`timescale 1ns/1ps

module tb_wave_capture;

  localparam int data_w     = 16;
  localparam int capt_depth = 16;
  // cycles a transfer may take before it counts as lost
  localparam int resp_wait  = 8;
  localparam int ev_test_end = 0;
  localparam int ev_poll     = 1;
  localparam int ev_no_resp  = 2;
  localparam int ev_summary  = 3;

  logic              clk;
  logic              rst;
  logic [data_w-1:0] din_i;
  logic [31:0]       paddr_i;
  logic              pwrite_i;
  logic [31:0]       pwdata_i;
  logic              psel_i;
  logic              penable_i;
  logic              pready_o;
  logic [31:0]       prdata_o;
  logic              pslverr_o;

  logic              chk_en;
  logic              chk_poll;
  logic [31:0]       exp_data;
  logic [31:0]       exp_mask;
  logic [127:0]      test_name;
  logic              test_end;
  logic              poll_expired;
  logic              no_resp;
  logic              summary;
  logic              match;
  int                errors;

  logic [7:0]        sample_cnt;
  int                cycles = 0;
  int                cycle_limit = 0;
  int                bad_lines = 0;

  // one entry per stimulus line
  byte               op_q[$];
  logic [31:0]       addr_q[$];
  logic [31:0]       data_q[$];
  logic [31:0]       mask_q[$];
  int                cnt_q[$];
  logic [127:0]      name_q[$];

  wave_capture #(.data_w(data_w), .capt_depth(capt_depth)) dut (
    .clk       (clk),
    .rst       (rst),
    .din_i     (din_i),
    .paddr_i   (paddr_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o)
  );

  cap_checker chk (
    .clk            (clk),
    .pready_i       (pready_o),
    .prdata_i       (prdata_o),
    .pslverr_i      (pslverr_o),
    .chk_en_i       (chk_en),
    .chk_poll_i     (chk_poll),
    .exp_data_i     (exp_data),
    .exp_mask_i     (exp_mask),
    .test_name_i    (test_name),
    .test_end_i     (test_end),
    .poll_expired_i (poll_expired),
    .no_resp_i      (no_resp),
    .summary_i      (summary),
    .match_o        (match),
    .errors_o       (errors)
  );

  always #4 clk = ~clk;

  // --------------------
  // sample source and timeout
  // --------------------
  // the low byte counts from reset so trigger values recur every 256 cycles
  always @(posedge clk) begin
    if (rst) begin
      sample_cnt <= 8'd0;
    end else begin
      sample_cnt <= sample_cnt + 8'd1;
    end
    din_i <= {8'hA5, sample_cnt};
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("simulation timed out after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------
  // stimulus file
  // --------------------
  task automatic load_ops();
    int           fd;
    int           got;
    string        line;
    logic [7:0]   c;
    logic [31:0]  a;
    logic [31:0]  d;
    logic [31:0]  m;
    int           n;
    logic [127:0] name;
    fd = $fopen("bench/wave_capture_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/wave_capture_testdata.txt");
      bad_lines++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          a    = '0;
          d    = '0;
          m    = '0;
          n    = 0;
          name = '0;
          c    = line.getc(0);
          if (c == "T") begin
            got = $sscanf(line, "%c %s", c, name);
          end else begin
            got = $sscanf(line, "%c %h %h %h %d", c, a, d, m, n);
          end
          if (!(c inside {"T", "W", "R", "P", "D"}) || got < 2) begin
            $display("stimulus line not understood: %s", line);
            bad_lines++;
          end
          op_q.push_back(c);
          addr_q.push_back(a);
          data_q.push_back(d);
          mask_q.push_back(m);
          cnt_q.push_back(n);
          name_q.push_back(name);
          // delays count in full and each transfer or poll retry gets 40 cycles
          if (c == "D") begin
            cycle_limit += n;
          end else if (c == "R" || c == "P") begin
            cycle_limit += 40 * (n + 1);
          end else begin
            cycle_limit += 40;
          end
        end
      end
      $fclose(fd);
      cycle_limit += 40;
    end
  endtask

  // --------------------
  // apb driver
  // --------------------
  // the extra cycle after the response lets match settle before it is read
  task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic check, input logic poll, input logic [31:0] exp,
                              input logic [31:0] mask, output logic ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    paddr_i   <= addr;
    pwrite_i  <= wr;
    pwdata_i  <= wdata;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    chk_en    <= check;
    chk_poll  <= poll;
    exp_data  <= exp;
    exp_mask  <= mask;
    @(posedge clk);
    penable_i <= 1'b1;
    while (!ok && waited < resp_wait) begin
      @(posedge clk);
      waited++;
      if (pready_o) begin
        ok = 1'b1;
      end
    end
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    chk_en    <= 1'b0;
    if (!ok) begin
      raise_event(ev_no_resp);
    end else begin
      @(posedge clk);
    end
  endtask

  // one-cycle strobe to the checker
  task automatic raise_event(input int which);
    case (which)
      ev_test_end: test_end     <= 1'b1;
      ev_poll:     poll_expired <= 1'b1;
      ev_no_resp:  no_resp      <= 1'b1;
      default:     summary      <= 1'b1;
    endcase
    @(posedge clk);
    test_end     <= 1'b0;
    poll_expired <= 1'b0;
    no_resp      <= 1'b0;
    summary      <= 1'b0;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    logic ok;
    logic matched;
    logic in_test;
    int   tries;
    clk          = 1'b0;
    rst          = 1'b1;
    din_i        = '0;
    paddr_i      = '0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    chk_en       = 1'b0;
    chk_poll     = 1'b0;
    exp_data     = '0;
    exp_mask     = '0;
    test_name    = '0;
    test_end     = 1'b0;
    poll_expired = 1'b0;
    no_resp      = 1'b0;
    summary      = 1'b0;
    in_test      = 1'b0;
    load_ops();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "T": begin
          if (in_test) begin
            raise_event(ev_test_end);
          end
          in_test = 1'b1;
          test_name <= name_q[i];
        end
        "W": apb_transfer(1'b1, addr_q[i], data_q[i], 1'b0, 1'b0, '0, '0, ok);
        "R": begin
          // a block read steps the address by a word and the expected value by one
          for (int j = 0; j < cnt_q[i]; j++) begin
            apb_transfer(1'b0, addr_q[i] + 32'(4 * j), '0, 1'b1, 1'b0,
                         data_q[i] + 32'(j), mask_q[i], ok);
          end
        end
        "P": begin
          matched = 1'b0;
          tries   = 0;
          while (!matched && tries < cnt_q[i]) begin
            apb_transfer(1'b0, addr_q[i], '0, 1'b1, 1'b1, data_q[i], mask_q[i], ok);
            matched = ok && match;
            tries++;
          end
          if (!matched) begin
            raise_event(ev_poll);
          end
        end
        "D": repeat (cnt_q[i]) @(posedge clk);
        default: ;
      endcase
    end
    if (in_test) begin
      raise_event(ev_test_end);
    end
    raise_event(ev_summary);
    @(posedge clk);
    if (errors == 0 && bad_lines == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: wave_capture.f
hdl/cap_pkg.sv
hdl/cap_cfg_if.sv
hdl/cap_ram.sv
hdl/trig_detect.sv
hdl/cap_engine.sv
hdl/cap_regs.sv
hdl/wave_capture.sv
bench/cap_checker.sv
bench/tb_wave_capture.sv

// File: Makefile
# Verilator build and run of the capture unit testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_wave_capture
FILELIST  ?= wave_capture.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/wave_capture_testdata.txt
# op byte_addr data mask count: T names a test, W writes data, R reads count words
# expecting data+k under mask, P polls until equal for count tries, D waits count cycles
T reg_access
R 00000000 5a7e0c01 ffffffff 1
R 00000004 00000010 ffffffff 1
R 00000008 00000010 ffffffff 1
R 00000030 deaddead ffffffff 1
W 0000000c 00000002 00000000 0
R 0000000c 00000002 ffffffff 1
W 00000020 0000beef 00000000 0
R 00000020 0000beef ffffffff 1
W 00000024 00001357 00000000 0
R 00000024 00001357 ffffffff 1
W 00000028 00002468 00000000 0
R 00000028 00002468 ffffffff 1
W 0000002c 00000ace 00000000 0
R 0000002c 00000ace ffffffff 1
W 00000010 00001234 00000000 0
R 00000010 00001234 ffffffff 1
W 00000014 000055aa 00000000 0
R 00000014 000055aa ffffffff 1
T single_rise
W 0000000c 00000001 00000000 0
W 00000020 000000ff 00000000 0
W 00000024 000000ff 00000000 0
W 00000028 0000003f 00000000 0
W 0000002c 00000040 00000000 0
W 00000010 00000000 00000000 0
W 00000014 00000000 00000000 0
W 00000018 00000001 00000000 0
P 0000001c 00000003 ffffffff 200
R 00000010 00000001 ffffffff 1
R 00000014 00000001 ffffffff 1
R 00002000 0000a540 ffffffff 16
T mode_none
W 00000018 00000000 00000000 0
W 0000000c 00000000 00000000 0
W 00000018 00000001 00000000 0
P 0000001c 00000003 ffffffff 50
R 00002000 0000a500 0000ff00 16
R 00000014 00000002 ffffffff 1
T continuous
W 00000018 00000000 00000000 0
W 00000014 00000000 00000000 0
W 0000000c 00000002 00000000 0
W 00000018 00000001 00000000 0
D 00000000 00000000 00000000 600
R 00000014 00000002 fffffffe 1
R 00002000 0000a540 ffffffff 16
T go_clear
W 00000018 00000000 00000000 0
R 0000001c 00000000 00000003 1
W 00000010 00000000 00000000 0
W 00000014 00000000 00000000 0
R 00000010 00000000 ffffffff 1
R 00000014 00000000 ffffffff 1
